//--- source/axil_reg_pkg.sv
`default_nettype none

package axil_reg_pkg;

  typedef struct packed {
    logic [31:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef enum logic [1:0] {
    OK     = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [31:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [31:0] data;
    axil_resp_e  resp;
  } axil_r_t;

  // register index, address bits 11:5
  typedef enum logic [6:0] {
    CTX      = 7'h00,
    CONN     = 7'h01,
    BOARDNUM = 7'h07,
    IPADDR   = 7'h08,
    ARP      = 7'h09,
    DEBUG    = 7'h0C
  } reg_addr_e;

  typedef enum logic [7:0] {
    CRC_DROPS = 8'd0,
    PSN_DROPS = 8'd1,
    RX_WORDS  = 8'd2,
    RX_PKGS   = 8'd3,
    TX_WORDS  = 8'd4,
    TX_PKGS   = 8'd5,
    ARP_RX    = 8'd6,
    ARP_TX    = 8'd7,
    NET_DOWN  = 8'd8
  } debug_idx_e;

  localparam int NUM_DEBUG_REGS = 9;

  typedef struct packed {
    logic [7:0][31:0] counters; // counters[i] is debug index i
    logic             net_down;
  } net_stats_t;

endpackage

`default_nettype wire

//--- source/net_cmd_pkg.sv
`default_nettype none

package net_cmd_pkg;

  typedef enum logic {
    QP_CTX  = 1'b0,
    QP_CONN = 1'b1
  } cmd_kind_e;

  localparam int CMD_WORDS = 7;

  typedef logic [183:0] cmd_payload_t;
  typedef logic [143:0] qp_ctx_t;  // 139 bits carry data
  typedef logic [183:0] qp_conn_t;

  typedef struct packed {
    logic [31:0] ip_addr;
  } arp_req_t;

  // bits each write word contributes, word 0 first
  localparam int unsigned CTX_SLICE_W [CMD_WORDS] = '{3, 24, 24, 24, 16, 32, 16};
  localparam int unsigned CONN_SLICE_W [CMD_WORDS] = '{16, 24, 32, 32, 32, 32, 16};

  function automatic int unsigned slice_w(cmd_kind_e kind, logic [2:0] k);
    int unsigned w;
    w = 0;
    for (int i = 0; i < CMD_WORDS; i++) begin
      if (k == 3'(i)) w = (kind == QP_CTX) ? CTX_SLICE_W[i] : CONN_SLICE_W[i];
    end
    return w;
  endfunction

  // low bit of word k, sum of all widths below it
  function automatic int unsigned slice_lo(cmd_kind_e kind, logic [2:0] k);
    int unsigned lo;
    lo = 0;
    for (int i = 0; i < CMD_WORDS; i++) begin
      if (3'(i) < k) lo += (kind == QP_CTX) ? CTX_SLICE_W[i] : CONN_SLICE_W[i];
    end
    return lo;
  endfunction

endpackage

`default_nettype wire

//--- source/axil_write_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module axil_write_fsm (
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  axil_reg_pkg::axil_aw_t    aw,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  axil_reg_pkg::axil_w_t     w,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axil_reg_pkg::axil_b_t     b,
  output logic                      b_valid,
  input  logic                      b_ready,
  output logic                      word_valid,
  output logic [31:0]               word_data,
  output net_cmd_pkg::cmd_kind_e    word_sel,
  input  logic                      ctx_done,
  input  logic                      conn_done,
  output logic                      set_ip_addr_valid,
  output logic [31:0]               set_ip_addr_data,
  output logic                      set_board_number_valid,
  output logic [3:0]                set_board_number_data,
  output net_cmd_pkg::arp_req_t     arp_req,
  output logic                      arp_req_valid,
  input  logic                      arp_req_ready
);
  import axil_reg_pkg::*;
  import net_cmd_pkg::*;

  typedef enum logic [2:0] {IDLE, DATA, WAIT_CMD, WAIT_ARP, RESP} wr_state_e;

  wr_state_e  state;
  logic [6:0] reg_idx; // latched from awaddr
  logic       cmd_done;

  assign b.resp   = OK; // writes never fail
  assign cmd_done = (word_sel == QP_CTX) ? ctx_done : conn_done;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state                  <= IDLE;
      aw_ready               <= 1'b0;
      w_ready                <= 1'b0;
      b_valid                <= 1'b0;
      word_valid             <= 1'b0;
      set_ip_addr_valid      <= 1'b0;
      set_board_number_valid <= 1'b0;
      arp_req_valid          <= 1'b0;
    end else begin
      word_valid             <= 1'b0; // single-cycle pulses
      set_ip_addr_valid      <= 1'b0;
      set_board_number_valid <= 1'b0;
      case (state)
        IDLE: begin
          aw_ready <= 1'b1;
          if (aw_valid && aw_ready) begin
            reg_idx  <= aw.addr[11:5];
            aw_ready <= 1'b0;
            w_ready  <= 1'b1;
            state    <= DATA;
          end
        end
        DATA: begin
          if (w_valid && w_ready) begin
            w_ready <= 1'b0;
            case (reg_idx)
              IPADDR: begin
                set_ip_addr_valid <= 1'b1;
                set_ip_addr_data  <= w.data;
                b_valid           <= 1'b1;
                state             <= RESP;
              end
              BOARDNUM: begin
                set_board_number_valid <= 1'b1;
                set_board_number_data  <= w.data[3:0];
                b_valid                <= 1'b1;
                state                  <= RESP;
              end
              ARP: begin
                // network byte order for the lookup
                arp_req.ip_addr <= {w.data[7:0], w.data[15:8], w.data[23:16], w.data[31:24]};
                arp_req_valid   <= 1'b1;
                state           <= WAIT_ARP;
              end
              CTX, CONN: begin
                word_valid <= 1'b1;
                word_data  <= w.data;
                word_sel   <= (reg_idx == CTX) ? QP_CTX : QP_CONN;
                state      <= WAIT_CMD;
              end
              default: begin // unmapped, just ack
                b_valid <= 1'b1;
                state   <= RESP;
              end
            endcase
          end
        end
        WAIT_CMD: begin
          if (cmd_done) begin // assembler finished this word
            b_valid <= 1'b1;
            state   <= RESP;
          end
        end
        WAIT_ARP: begin
          if (arp_req_valid && arp_req_ready) begin
            arp_req_valid <= 1'b0;
            b_valid       <= 1'b1;
            state         <= RESP;
          end
        end
        RESP: begin
          if (b_valid && b_ready) begin
            b_valid  <= 1'b0;
            aw_ready <= 1'b1; // ready for next write right away
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // lookup request stays up with the same address until taken
  arp_hold_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    arp_req_valid && !arp_req_ready |=> arp_req_valid && $stable(arp_req));

  ip_strobe_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    set_ip_addr_valid |=> !set_ip_addr_valid);

  board_strobe_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    set_board_number_valid |=> !set_board_number_valid);

endmodule

`default_nettype wire

//--- source/qp_cmd_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module qp_cmd_assembler #(
  parameter net_cmd_pkg::cmd_kind_e CMD_KIND = net_cmd_pkg::QP_CTX
) (
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  logic                      word_valid,
  input  logic [31:0]               word_data,
  input  net_cmd_pkg::cmd_kind_e    word_sel,
  output net_cmd_pkg::cmd_payload_t payload,
  output logic                      payload_valid,
  input  logic                      payload_ready,
  output logic                      done
);
  import net_cmd_pkg::*;

  localparam logic [2:0] LAST_WORD = 3'(CMD_WORDS - 1);

  logic [2:0]   word_cnt;
  logic         take;      // word addressed to this kind
  int unsigned  slot_w;
  int unsigned  slot_lo;
  cmd_payload_t word_mask;
  cmd_payload_t slot_bits; // word moved to its place in the payload

  assign take = word_valid && (word_sel == CMD_KIND);

  always_comb begin
    slot_w    = slice_w(CMD_KIND, word_cnt);
    slot_lo   = slice_lo(CMD_KIND, word_cnt);
    word_mask = (cmd_payload_t'(1) << slot_w) - cmd_payload_t'(1);
    slot_bits = (cmd_payload_t'(word_data) & word_mask) << slot_lo;
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      word_cnt      <= '0;
      payload_valid <= 1'b0;
      done          <= 1'b0;
    end else begin
      done <= 1'b0;
      if (take) begin
        if (word_cnt == LAST_WORD) begin
          payload_valid <= 1'b1; // done waits for the handshake
        end else begin
          word_cnt <= word_cnt + 3'd1;
          done     <= 1'b1;
        end
      end
      if (payload_valid && payload_ready) begin
        payload_valid <= 1'b0;
        done          <= 1'b1;
        word_cnt      <= '0;
      end
    end
  end

  // word 0 starts from zero, so unused upper bits stay clear
  always_ff @(posedge net_clk) begin
    if (take) begin
      payload <= (word_cnt == '0) ? slot_bits : (payload | slot_bits);
    end
  end

  // writer waits for done, so a new word never overlaps a pending payload
  no_word_while_busy_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    !(take && payload_valid));

endmodule

`default_nettype wire

//--- source/debug_reg_reader.sv
`timescale 1ns/1ns
`default_nettype none

module debug_reg_reader (
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  axil_reg_pkg::axil_ar_t    ar,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output axil_reg_pkg::axil_r_t     r,
  output logic                      r_valid,
  input  logic                      r_ready,
  input  axil_reg_pkg::net_stats_t  stats
);
  import axil_reg_pkg::*;

  typedef enum logic {IDLE, RESP} rd_state_e;

  localparam logic [7:0] LAST_IDX = 8'(NUM_DEBUG_REGS - 1);

  rd_state_e  state;
  logic [6:0] rd_idx;  // register index of pending read
  logic [7:0] dbg_idx; // next debug counter to return

  // response mux, stays put while rvalid is held
  always_comb begin
    r.resp = OK;
    r.data = 32'h0;
    if (rd_idx == DEBUG) begin
      if (dbg_idx <= ARP_TX) begin
        r.data = stats.counters[dbg_idx[2:0]];
      end else if (dbg_idx == NET_DOWN) begin
        r.data = {31'h0, stats.net_down};
      end else begin
        r.resp = SLVERR; // index past the table
      end
    end else begin
      r.resp = SLVERR;
      r.data = 32'hdeadbeef;
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state    <= IDLE;
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      dbg_idx  <= CRC_DROPS;
    end else begin
      case (state)
        IDLE: begin
          ar_ready <= 1'b1;
          if (ar_valid && ar_ready) begin
            rd_idx   <= ar.addr[11:5];
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
            state    <= RESP;
          end
        end
        RESP: begin
          if (r_valid && r_ready) begin
            r_valid  <= 1'b0;
            ar_ready <= 1'b1;
            state    <= IDLE;
            if (rd_idx == DEBUG) begin // auto-increment, wraps to first counter
              dbg_idx <= (dbg_idx == LAST_IDX) ? CRC_DROPS : dbg_idx + 8'd1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  dbg_idx_range_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    dbg_idx < 8'(NUM_DEBUG_REGS));

endmodule

`default_nettype wire

//--- source/net_controller.sv
`timescale 1ns/1ns
`default_nettype none

module net_controller (
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  axil_reg_pkg::axil_aw_t    aw,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  axil_reg_pkg::axil_w_t     w,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axil_reg_pkg::axil_b_t     b,
  output logic                      b_valid,
  input  logic                      b_ready,
  input  axil_reg_pkg::axil_ar_t    ar,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output axil_reg_pkg::axil_r_t     r,
  output logic                      r_valid,
  input  logic                      r_ready,
  output net_cmd_pkg::qp_ctx_t      qp_ctx,
  output logic                      qp_ctx_valid,
  input  logic                      qp_ctx_ready,
  output net_cmd_pkg::qp_conn_t     qp_conn,
  output logic                      qp_conn_valid,
  input  logic                      qp_conn_ready,
  output net_cmd_pkg::arp_req_t     arp_req,
  output logic                      arp_req_valid,
  input  logic                      arp_req_ready,
  output logic                      set_ip_addr_valid,
  output logic [31:0]               set_ip_addr_data,
  output logic                      set_board_number_valid,
  output logic [3:0]                set_board_number_data,
  input  axil_reg_pkg::net_stats_t  stats
);
  import net_cmd_pkg::*;

  logic         word_valid;
  logic [31:0]  word_data;
  cmd_kind_e    word_sel;
  logic         ctx_done;
  logic         conn_done;
  cmd_payload_t ctx_payload; // full width, ctx uses the low part

  assign qp_ctx = ctx_payload[143:0];

  axil_write_fsm wr_fsm (
    .net_clk, .net_aresetn,
    .aw, .aw_valid, .aw_ready,
    .w, .w_valid, .w_ready,
    .b, .b_valid, .b_ready,
    .word_valid, .word_data, .word_sel,
    .ctx_done, .conn_done,
    .set_ip_addr_valid, .set_ip_addr_data,
    .set_board_number_valid, .set_board_number_data,
    .arp_req, .arp_req_valid, .arp_req_ready
  );

  qp_cmd_assembler #(.CMD_KIND(QP_CTX)) ctx_asm (
    .net_clk, .net_aresetn,
    .word_valid, .word_data, .word_sel,
    .payload(ctx_payload), .payload_valid(qp_ctx_valid), .payload_ready(qp_ctx_ready),
    .done(ctx_done)
  );

  qp_cmd_assembler #(.CMD_KIND(QP_CONN)) conn_asm (
    .net_clk, .net_aresetn,
    .word_valid, .word_data, .word_sel,
    .payload(qp_conn), .payload_valid(qp_conn_valid), .payload_ready(qp_conn_ready),
    .done(conn_done)
  );

  debug_reg_reader rd_ctrl (
    .net_clk, .net_aresetn,
    .ar, .ar_valid, .ar_ready,
    .r, .r_valid, .r_ready,
    .stats
  );

endmodule

`default_nettype wire

//--- tb/tb_net_tasks.svh
// selects one DUT handshake output for the wait loops
function automatic logic pick_sig(input int sel);
  case (sel)
    SIG_AW_READY: return aw_ready;
    SIG_W_READY:  return w_ready;
    SIG_B_VALID:  return b_valid;
    SIG_AR_READY: return ar_ready;
    default:      return r_valid;
  endcase
endfunction

// returns on the negedge before the edge that completes the handshake
task automatic wait_sig(input int sel, input string what);
  int n;
  n = 0;
  @(negedge net_clk);
  while (!pick_sig(sel)) begin
    n++;
    if (n > TIMEOUT_CYCLES) begin
      $display("timed out waiting for %s", what);
      timeouts++;
      aborted = 1'b1;
      return;
    end
    @(negedge net_clk);
  end
endtask

// ready kept low, valid must not drop meanwhile
task automatic hold_ready_stall(input int cycles, input int sel, input string what);
  repeat (cycles) begin
    @(posedge net_clk);
    @(negedge net_clk);
    if (!pick_sig(sel)) begin
      $display("%s dropped before its ready was given", what);
      other_errs++;
    end
  end
endtask

task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    val_errs++;
  end
endtask

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    val_errs++;
  end
endtask

task automatic check_arp(input string name, input arp_req_t got, input arp_req_t exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    val_errs++;
  end
endtask

task automatic check_ctx(input string name, input qp_ctx_t got, input qp_ctx_t exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    val_errs++;
  end
endtask

task automatic check_conn(input string name, input qp_conn_t got, input qp_conn_t exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    val_errs++;
  end
endtask

// low bits of each word stacked upward, word 0 at bit 0
function automatic logic [183:0] pack_cmd(input bit conn);
  logic [183:0] p;
  int pos;
  int wd;
  p = '0;
  pos = 0;
  for (int k = 0; k < WORDS; k++) begin
    wd = conn ? CONN_BITS[k] : CTX_BITS[k];
    for (int i = 0; i < wd; i++) begin
      p[pos] = conn ? conn_buf[k][i] : ctx_buf[k][i];
      pos++;
    end
  end
  return p;
endfunction

task automatic set_stat(input logic [31:0] idx, input logic [31:0] data);
  if (idx < 8)
    stats.counters[idx[2:0]] = data;
  else
    stats.net_down = data[0]; // index 8 is the link-down bit
endtask

task automatic do_write(input logic [6:0] idx, input logic [31:0] data,
                        input logic [31:0] exp, input int stall);
  int ip0;
  int board0;
  int arp0;
  int ctx0;
  int conn0;
  int n;
  int left;
  bit hs;
  bit dn;
  bit last_ctx;
  bit last_conn;
  ip0 = ip_cnt;
  board0 = board_cnt;
  arp0 = arp_cnt;
  ctx0 = ctx_cnt;
  conn0 = conn_cnt;
  last_ctx = (idx == CTX) && (ctx_n == WORDS - 1);
  last_conn = (idx == CONN) && (conn_n == WORDS - 1);
  if (idx == CTX)
    ctx_buf[ctx_n] = data;
  if (idx == CONN)
    conn_buf[conn_n] = data;
  aw.addr = {20'h0, idx, 5'h0}; // register index sits in bits 11:5
  aw_valid = 1'b1;
  w.data = data;
  w.strb = 4'hf;
  w_valid = 1'b1;
  wait_sig(SIG_AW_READY, "awready");
  if (aborted)
    return;
  @(posedge net_clk);
  #DRIVE_DLY;
  aw_valid = 1'b0;
  wait_sig(SIG_W_READY, "wready");
  if (aborted)
    return;
  @(posedge net_clk);
  #DRIVE_DLY;
  w_valid = 1'b0;
  hs = 1'b0;
  left = stall;
  n = 0;
  while (1) begin // serve downstream ready until bvalid
    @(negedge net_clk);
    if ((arp_req_valid && arp_req_ready) || (qp_ctx_valid && qp_ctx_ready) ||
        (qp_conn_valid && qp_conn_ready))
      hs = 1'b1;
    if (b_valid)
      break;
    n++;
    if (n > TIMEOUT_CYCLES) begin
      $display("timed out waiting for the write response of register 0x%h", idx);
      timeouts++;
      aborted = 1'b1;
      return;
    end
    dn = arp_req_valid || qp_ctx_valid || qp_conn_valid;
    @(posedge net_clk);
    #DRIVE_DLY;
    if (hs) begin
      arp_req_ready = 1'b0;
      qp_ctx_ready = 1'b0;
      qp_conn_ready = 1'b0;
    end else if (dn && left > 0) begin
      left--; // downstream stalled
    end else if (dn) begin
      arp_req_ready = arp_req_valid;
      qp_ctx_ready = qp_ctx_valid;
      qp_conn_ready = qp_conn_valid;
    end
  end
  if ((idx == ARP || last_ctx || last_conn) && !hs) begin
    $display("write response to register 0x%h came before the downstream transfer", idx);
    other_errs++;
  end
  hold_ready_stall(stall, SIG_B_VALID, "bvalid");
  @(posedge net_clk);
  #DRIVE_DLY;
  arp_req_ready = 1'b0;
  qp_ctx_ready = 1'b0;
  qp_conn_ready = 1'b0;
  b_ready = 1'b1;
  @(negedge net_clk);
  check_resp("bresp", b.resp, OK);
  @(posedge net_clk);
  #DRIVE_DLY;
  b_ready = 1'b0;
  // exactly one effect per register, none for unmapped ones
  check_data("set_ip_addr strobes", 32'(ip_cnt - ip0), {31'h0, idx == IPADDR});
  check_data("set_board_number strobes", 32'(board_cnt - board0), {31'h0, idx == BOARDNUM});
  check_data("arp_req transfers", 32'(arp_cnt - arp0), {31'h0, idx == ARP});
  check_data("qp_ctx transfers", 32'(ctx_cnt - ctx0), {31'h0, last_ctx});
  check_data("qp_conn transfers", 32'(conn_cnt - conn0), {31'h0, last_conn});
  if (idx == IPADDR)
    check_data("set_ip_addr_data", ip_seen, exp);
  if (idx == BOARDNUM)
    check_data("set_board_number_data", 32'(board_seen), exp);
  if (idx == ARP)
    check_arp("arp_req", arp_seen, arp_req_t'(exp));
  if (last_ctx)
    check_ctx("qp_ctx", ctx_seen, qp_ctx_t'(pack_cmd(1'b0)));
  if (last_conn)
    check_conn("qp_conn", conn_seen, qp_conn_t'(pack_cmd(1'b1)));
  if (idx == CTX)
    ctx_n = (ctx_n + 1) % WORDS;
  if (idx == CONN)
    conn_n = (conn_n + 1) % WORDS;
endtask

task automatic do_read(input logic [6:0] idx, input logic [31:0] exp, input int stall);
  axil_resp_e exp_resp;
  exp_resp = (idx == DEBUG) ? OK : SLVERR; // only the debug window is mapped for reads
  ar.addr = {20'h0, idx, 5'h0};
  ar_valid = 1'b1;
  wait_sig(SIG_AR_READY, "arready");
  if (aborted)
    return;
  @(posedge net_clk);
  #DRIVE_DLY;
  ar_valid = 1'b0;
  wait_sig(SIG_R_VALID, "rvalid");
  if (aborted)
    return;
  hold_ready_stall(stall, SIG_R_VALID, "rvalid");
  @(posedge net_clk);
  #DRIVE_DLY;
  r_ready = 1'b1;
  @(negedge net_clk);
  check_data("rdata", r.data, exp);
  check_resp("rresp", r.resp, exp_resp);
  @(posedge net_clk);
  #DRIVE_DLY;
  r_ready = 1'b0;
endtask

//--- tb/tb_net_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_net_controller;
  import axil_reg_pkg::*;
  import net_cmd_pkg::*;

  localparam int DRIVE_DLY = 10; // inputs move this long after posedge
  localparam int TIMEOUT_CYCLES = 64;
  localparam int WORDS = 7;
  localparam logic [31:0] RAND_SEED = 32'h20f8_07c8;
  localparam int SIG_AW_READY = 0;
  localparam int SIG_W_READY = 1;
  localparam int SIG_B_VALID = 2;
  localparam int SIG_AR_READY = 3;
  localparam int SIG_R_VALID = 4;
  // bits taken from each command word
  localparam int CTX_BITS [WORDS] = '{3, 24, 24, 24, 16, 32, 16};
  localparam int CONN_BITS [WORDS] = '{16, 24, 32, 32, 32, 32, 16};

  logic        net_clk = 1'b0;
  logic        net_aresetn;
  axil_aw_t    aw;
  logic        aw_valid;
  logic        aw_ready;
  axil_w_t     w;
  logic        w_valid;
  logic        w_ready;
  axil_b_t     b;
  logic        b_valid;
  logic        b_ready;
  axil_ar_t    ar;
  logic        ar_valid;
  logic        ar_ready;
  axil_r_t     r;
  logic        r_valid;
  logic        r_ready;
  qp_ctx_t     qp_ctx;
  logic        qp_ctx_valid;
  logic        qp_ctx_ready;
  qp_conn_t    qp_conn;
  logic        qp_conn_valid;
  logic        qp_conn_ready;
  arp_req_t    arp_req;
  logic        arp_req_valid;
  logic        arp_req_ready;
  logic        set_ip_addr_valid;
  logic [31:0] set_ip_addr_data;
  logic        set_board_number_valid;
  logic [3:0]  set_board_number_data;
  net_stats_t  stats;

  int          val_errs;
  int          timeouts;
  int          other_errs;
  bit          aborted;    // stops the stimulus loop
  int          ip_cnt;     // strobes and transfers seen by the monitor
  int          board_cnt;
  int          arp_cnt;
  int          ctx_cnt;
  int          conn_cnt;
  logic [31:0] ip_seen;
  logic [3:0]  board_seen;
  arp_req_t    arp_seen;
  qp_ctx_t     ctx_seen;
  qp_conn_t    conn_seen;
  logic [31:0] ctx_buf [WORDS];
  logic [31:0] conn_buf [WORDS];
  int          ctx_n;      // next command word slot
  int          conn_n;

  `include "tb_net_tasks.svh"

  always #50 net_clk = ~net_clk;

  net_controller UUT (
    .net_clk, .net_aresetn,
    .aw, .aw_valid, .aw_ready,
    .w, .w_valid, .w_ready,
    .b, .b_valid, .b_ready,
    .ar, .ar_valid, .ar_ready,
    .r, .r_valid, .r_ready,
    .qp_ctx, .qp_ctx_valid, .qp_ctx_ready,
    .qp_conn, .qp_conn_valid, .qp_conn_ready,
    .arp_req, .arp_req_valid, .arp_req_ready,
    .set_ip_addr_valid, .set_ip_addr_data,
    .set_board_number_valid, .set_board_number_data,
    .stats
  );

  // sampled on negedge with outputs settled
  always @(negedge net_clk) begin
    if (net_aresetn) begin
      if (set_ip_addr_valid) begin
        ip_cnt++;
        ip_seen = set_ip_addr_data;
      end
      if (set_board_number_valid) begin
        board_cnt++;
        board_seen = set_board_number_data;
      end
      if (arp_req_valid && arp_req_ready) begin // transfer on the coming edge
        arp_cnt++;
        arp_seen = arp_req;
      end
      if (qp_ctx_valid && qp_ctx_ready) begin
        ctx_cnt++;
        ctx_seen = qp_ctx;
      end
      if (qp_conn_valid && qp_conn_ready) begin
        conn_cnt++;
        conn_seen = qp_conn;
      end
    end
  end

  initial begin
    int          fd;
    int          rc;
    int          cnt;
    int          stall;
    int          stall_cyc;
    string       line;
    byte         op;
    logic [31:0] idx_raw;
    logic [31:0] data;
    logic [31:0] exp;
    void'($urandom(RAND_SEED));
    val_errs = 0;
    timeouts = 0;
    other_errs = 0;
    aborted = 1'b0;
    ip_cnt = 0;
    board_cnt = 0;
    arp_cnt = 0;
    ctx_cnt = 0;
    conn_cnt = 0;
    ctx_n = 0;
    conn_n = 0;
    net_aresetn = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    qp_ctx_ready = 1'b0;
    qp_conn_ready = 1'b0;
    arp_req_ready = 1'b0;
    stats = '0;
    repeat (3) @(posedge net_clk);
    #DRIVE_DLY;
    net_aresetn = 1'b1;
    @(negedge net_clk);
    // readies still low in the first cycle out of reset
    check_data("valids and readies after reset",
               {22'h0, aw_ready, w_ready, ar_ready, b_valid, r_valid,
                qp_ctx_valid, qp_conn_valid, arp_req_valid, set_ip_addr_valid,
                set_board_number_valid}, 32'h0);
    @(posedge net_clk);
    #DRIVE_DLY;
    fd = $fopen("tb/net_controller_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/net_controller_stim.txt");
      other_errs++;
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      cnt = $sscanf(line, "%c %h %h %h %d", op, idx_raw, data, exp, stall);
      if (rc == 0 || cnt != 5)
        continue; // comment or blank line
      stall_cyc = (stall > 0) ? stall + int'($urandom % 3) : 0;
      case (op)
        "W": do_write(idx_raw[6:0], data, exp, stall_cyc);
        "R": do_read(idx_raw[6:0], exp, stall_cyc);
        "S": set_stat(idx_raw, data);
        default: begin
          $display("unknown operation %c in the stimulus file", op);
          other_errs++;
        end
      endcase
    end
    if (fd != 0)
      $fclose(fd);
    $display("errors: %0d value mismatches, %0d timeouts, %0d other failures",
             val_errs, timeouts, other_errs);
    if (val_errs + timeouts + other_errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- net_controller.f
+incdir+tb
source/axil_reg_pkg.sv
source/net_cmd_pkg.sv
source/axil_write_fsm.sv
source/qp_cmd_assembler.sv
source/debug_reg_reader.sv
source/net_controller.sv
tb/tb_net_controller.sv

//--- Makefile
TOP = tb_net_controller
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		--top-module $(TOP) -f net_controller.f
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "Test FAILED" $(LOG); then echo "failure reported, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/net_controller_stim.txt
# op reg data expected stall    (hex except stall, which is decimal)
# W write, R read, S set counter where reg is the debug index
W 08 c0a80a02 c0a80a02 2
W 07 0000003b 0000000b 0
W 09 0a0b0c0d 0d0c0b0a 3
W 00 ffffffff 00000000 0
W 00 11a1b2c3 00000000 0
W 00 22d4e5f6 00000000 0
W 00 33123456 00000000 0
W 00 4400abcd 00000000 0
W 00 deadbeef 00000000 0
W 00 66005a5a 00000000 1
W 01 aaaa1234 00000000 0
W 01 bb0f1e2d 00000000 0
W 01 01234567 00000000 0
W 01 89abcdef 00000000 0
W 01 fedcba98 00000000 0
W 01 76543210 00000000 0
W 01 cccc4321 00000000 4
S 00 00000011 00000000 0
S 01 00000022 00000000 0
S 02 12345678 00000000 0
S 03 00abcdef 00000000 0
S 04 87654321 00000000 0
S 05 0000beef 00000000 0
S 06 00000007 00000000 0
S 07 00000009 00000000 0
S 08 00000001 00000000 0
R 0c 00000000 00000011 0
R 0c 00000000 00000022 2
R 0c 00000000 12345678 0
R 0c 00000000 00abcdef 0
R 0c 00000000 87654321 1
R 0c 00000000 0000beef 0
R 0c 00000000 00000007 0
R 0c 00000000 00000009 0
R 0c 00000000 00000001 0
R 0c 00000000 00000011 0
R 0c 00000000 00000022 0
R 05 00000000 deadbeef 0
W 05 12345678 00000000 0
